// ==== uninasoc_macros.svh ====
// uninasoc parameters: bus widths, memory and queue depths, address map
`ifndef UNINASOC_MACROS_SVH
`define UNINASOC_MACROS_SVH

// bus widths
`define BUS_ADDR_WIDTH 32
`define BUS_DATA_WIDTH 32

// sizes
`define MEM_WORDS      256   // main memory depth in words
`define REQ_FIFO_DEPTH 4     // request queue entries
`define NUM_IRQ_SRC    4     // peripheral interrupt lines

// address map, region selector is addr[31:28]
`define MEM_BASE   32'h0000_0000
`define PLIC_BASE  32'h4000_0000
`define REGION_MSB 31

`endif

// ==== uninasoc_pkg.sv ====
// uninasoc shared types: bus fields, interrupt vector and decode enums
`include "uninasoc_macros.svh"

package uninasoc_pkg;

    ////////////////////////////////////////
    // bus fields
    ////////////////////////////////////////

    typedef logic [`BUS_ADDR_WIDTH-1:0] bus_addr_t;
    typedef logic [`BUS_DATA_WIDTH-1:0] bus_data_t;
    typedef logic [`NUM_IRQ_SRC-1:0]    irq_vec_t;   // one bit per source

    typedef enum logic [0:0] {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_e;

    // target slave, decoded once in the master
    typedef enum logic [1:0] {
        SEL_MEM  = 2'd0,
        SEL_PLIC = 2'd1,
        SEL_NONE = 2'd2   // unmapped or misaligned
    } slave_sel_e;

    // plic register index, address bit 2
    typedef enum logic [0:0] {
        PLIC_ENABLE  = 1'b0,   // offset 0x0
        PLIC_PENDING = 1'b1    // offset 0x4
    } plic_reg_e;

endpackage : uninasoc_pkg

// ==== soc_bus_if.sv ====
// single-beat request bus with valid/ready handshake between soc blocks
`timescale 1ns/10ps

interface soc_bus_if;

    import uninasoc_pkg::*;

    logic       valid;   // request present
    logic       ready;   // receiver can take it
    bus_op_e    op;
    slave_sel_e sel;     // pre-decoded target
    bus_addr_t  addr;
    bus_data_t  wdata;

    // request sender
    modport master (
        output valid, op, sel, addr, wdata,
        input  ready
    );

    // request receiver
    modport slave (
        input  valid, op, sel, addr, wdata,
        output ready
    );

endinterface : soc_bus_if

// ==== main_memory.sv ====
// main memory: word-addressed single-port ram with registered read
`timescale 1ns/10ps
`include "uninasoc_macros.svh"

module main_memory (
    input  logic                    sys_clock_i,
    input  logic                    mem_sel_i,
    input  logic                    mem_we_i,
    input  uninasoc_pkg::bus_addr_t mem_addr_i,
    input  uninasoc_pkg::bus_data_t mem_wdata_i,
    output uninasoc_pkg::bus_data_t mem_rdata_o
);

    import uninasoc_pkg::*;

    localparam int WORDS = `MEM_WORDS;
    localparam int IDX_W = $clog2(WORDS);

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    bus_data_t        mem_q [WORDS];   // contents unknown at power-up
    logic [IDX_W-1:0] word_idx;

    // byte address to word index, upper bits alias
    assign word_idx = mem_addr_i[IDX_W+1:2];

    ////////////////////////////////////////
    // access port
    ////////////////////////////////////////

    always_ff @(posedge sys_clock_i) begin
        if (mem_sel_i) begin
            if (mem_we_i) begin
                mem_q[word_idx] <= mem_wdata_i;   // full word only
            end else begin
                mem_rdata_o <= mem_q[word_idx];   // ready the edge after select
            end
        end
    end

endmodule : main_memory

// ==== plic.sv ====
// interrupt controller merging pending and enable registers into one platform irq
`timescale 1ns/10ps
`include "uninasoc_macros.svh"

module plic (
    input  logic                    sys_clock_i,
    input  logic                    rst_i,
    input  logic                    plic_sel_i,
    input  logic                    plic_we_i,
    input  uninasoc_pkg::plic_reg_e plic_reg_i,
    input  uninasoc_pkg::bus_data_t plic_wdata_i,
    input  uninasoc_pkg::irq_vec_t  irq_src_i,
    output uninasoc_pkg::bus_data_t plic_rdata_o,
    output logic                    irq_o
);

    import uninasoc_pkg::*;

    localparam int PAD_W = `BUS_DATA_WIDTH - `NUM_IRQ_SRC;

    irq_vec_t enable_q;    // per-source mask
    irq_vec_t pending_q;   // level captured from sources
    irq_vec_t clr_mask;    // write-1-clear bits
    logic     wr_enable, wr_pending;

    assign wr_enable  = plic_sel_i && plic_we_i && (plic_reg_i == PLIC_ENABLE);
    assign wr_pending = plic_sel_i && plic_we_i && (plic_reg_i == PLIC_PENDING);
    assign clr_mask   = wr_pending ? plic_wdata_i[`NUM_IRQ_SRC-1:0] : '0;

    ////////////////////////////////////////
    // gateway
    ////////////////////////////////////////

    always_ff @(posedge sys_clock_i) begin
        if (rst_i) begin
            enable_q  <= '0;
            pending_q <= '0;
        end else begin
            if (wr_enable) enable_q <= plic_wdata_i[`NUM_IRQ_SRC-1:0];
            // a live source wins over the clear
            pending_q <= (pending_q & ~clr_mask) | irq_src_i;
        end
    end

    // target output one edge behind pending and enable
    always_ff @(posedge sys_clock_i) begin
        if (rst_i) begin
            irq_o <= 1'b0;
        end else begin
            irq_o <= |(pending_q & enable_q);
        end
    end

    ////////////////////////////////////////
    // register read
    ////////////////////////////////////////

    always_ff @(posedge sys_clock_i) begin
        if (plic_sel_i && !plic_we_i) begin
            case (plic_reg_i)
                PLIC_ENABLE:  plic_rdata_o <= {{PAD_W{1'b0}}, enable_q};
                PLIC_PENDING: plic_rdata_o <= {{PAD_W{1'b0}}, pending_q};
                default:      plic_rdata_o <= '0;
            endcase
        end
    end

    // an enabled source that is high reaches irq_o two edges later
    a_src_raises_irq: assert property (@(posedge sys_clock_i) disable iff (rst_i)
        !$past(rst_i) && !$past(rst_i, 2) &&
        (($past(irq_src_i, 2) & $past(enable_q)) != '0) |-> irq_o);

endmodule : plic

// ==== main_bus.sv ====
// main bus: routes queued requests to memory or plic and holds the response
`timescale 1ns/10ps

module main_bus (
    input  logic                    sys_clock_i,
    input  logic                    rst_i,
    soc_bus_if.slave                s_bus,
    input  logic                    host_rsp_ready_i,
    output logic                    host_rsp_valid_o,
    output uninasoc_pkg::bus_data_t host_rdata_o,
    output logic                    host_rsp_err_o,
    input  uninasoc_pkg::irq_vec_t  irq_src_i,
    output logic                    irq_o
);

    import uninasoc_pkg::*;

    logic       rsp_valid_q, rsp_err_q, rsp_read_q;
    slave_sel_e rsp_src_q;   // who answered
    logic       accept, mem_sel, plic_sel, req_we;
    bus_data_t  mem_rdata, plic_rdata;
    plic_reg_e  plic_reg;

    // take a request while the response slot is empty or draining
    assign s_bus.ready = !rsp_valid_q || host_rsp_ready_i;
    assign accept      = s_bus.valid && s_bus.ready;
    assign mem_sel     = accept && (s_bus.sel == SEL_MEM);
    assign plic_sel    = accept && (s_bus.sel == SEL_PLIC);
    assign req_we      = (s_bus.op == OP_WRITE);
    assign plic_reg    = plic_reg_e'(s_bus.addr[2]);

    ////////////////////////////////////////
    // response register
    ////////////////////////////////////////

    always_ff @(posedge sys_clock_i) begin
        if (rst_i) begin
            rsp_valid_q <= 1'b0;
            rsp_src_q   <= SEL_NONE;
            rsp_err_q   <= 1'b0;
            rsp_read_q  <= 1'b0;
        end else if (accept) begin
            rsp_valid_q <= 1'b1;
            rsp_src_q   <= s_bus.sel;
            rsp_err_q   <= (s_bus.sel == SEL_NONE);   // nobody mapped there
            rsp_read_q  <= !req_we;
        end else if (host_rsp_ready_i) begin
            rsp_valid_q <= 1'b0;   // host took it
        end
    end

    // slave read regs only move on a new accept, so data holds too
    always_comb begin
        host_rdata_o = '0;   // writes and errors read zero
        if (rsp_read_q) begin
            case (rsp_src_q)
                SEL_MEM:  host_rdata_o = mem_rdata;
                SEL_PLIC: host_rdata_o = plic_rdata;
                default:  host_rdata_o = '0;
            endcase
        end
    end

    assign host_rsp_valid_o = rsp_valid_q;
    assign host_rsp_err_o   = rsp_err_q;

    ////////////////////////////////////////
    // slaves
    ////////////////////////////////////////

    main_memory i_main_memory (
        .sys_clock_i ( sys_clock_i ),
        .mem_sel_i   ( mem_sel     ),
        .mem_we_i    ( req_we      ),
        .mem_addr_i  ( s_bus.addr  ),
        .mem_wdata_i ( s_bus.wdata ),
        .mem_rdata_o ( mem_rdata   )
    );

    plic i_plic (
        .sys_clock_i  ( sys_clock_i ),
        .rst_i        ( rst_i       ),
        .plic_sel_i   ( plic_sel    ),
        .plic_we_i    ( req_we      ),
        .plic_reg_i   ( plic_reg    ),
        .plic_wdata_i ( s_bus.wdata ),
        .irq_src_i    ( irq_src_i   ),
        .plic_rdata_o ( plic_rdata  ),
        .irq_o        ( irq_o       )
    );

endmodule : main_bus

// ==== req_fifo.sv ====
// request queue: circular buffer between the system master and the main bus
`timescale 1ns/10ps
`include "uninasoc_macros.svh"

module req_fifo (
    input  logic      sys_clock_i,
    input  logic      rst_i,
    soc_bus_if.slave  s_bus,
    soc_bus_if.master m_bus
);

    import uninasoc_pkg::*;

    localparam int DEPTH = `REQ_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // entry storage, one array per field
    bus_op_e    op_q    [DEPTH];
    slave_sel_e sel_q   [DEPTH];
    bus_addr_t  addr_q  [DEPTH];
    bus_data_t  wdata_q [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;   // occupied entries
    logic             push, pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign s_bus.ready = (count_q != CNT_W'(DEPTH));   // full blocks the master
    assign m_bus.valid = (count_q != '0);
    assign push        = s_bus.valid && s_bus.ready;
    assign pop         = m_bus.valid && m_bus.ready;

    ////////////////////////////////////////
    // pointers and count
    ////////////////////////////////////////

    always_ff @(posedge sys_clock_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
            if (pop)  rd_ptr_q <= next_ptr(rd_ptr_q);
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;   // idle or both
            endcase
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (push) begin
            op_q[wr_ptr_q]    <= s_bus.op;
            sel_q[wr_ptr_q]   <= s_bus.sel;
            addr_q[wr_ptr_q]  <= s_bus.addr;
            wdata_q[wr_ptr_q] <= s_bus.wdata;
        end
    end

    // head entry, registered storage so no fall-through
    assign m_bus.op    = op_q[rd_ptr_q];
    assign m_bus.sel   = sel_q[rd_ptr_q];
    assign m_bus.addr  = addr_q[rd_ptr_q];
    assign m_bus.wdata = wdata_q[rd_ptr_q];

    // a write lands on a free slot, a read takes a written one
    a_no_write_full: assert property (@(posedge sys_clock_i) disable iff (rst_i)
        push |-> (count_q == '0) || (wr_ptr_q != rd_ptr_q));
    a_no_read_empty: assert property (@(posedge sys_clock_i) disable iff (rst_i)
        pop |-> (count_q == CNT_W'(DEPTH)) || (wr_ptr_q != rd_ptr_q));

endmodule : req_fifo

// ==== sys_master.sv ====
// system master: registers host commands and decodes them into bus requests
`timescale 1ns/10ps
`include "uninasoc_macros.svh"

module sys_master (
    input  logic                  sys_clock_i,
    input  logic                  rst_i,
    input  logic                  host_req_i,
    input  logic                  host_we_i,
    input  uninasoc_pkg::bus_addr_t host_addr_i,
    input  uninasoc_pkg::bus_data_t host_wdata_i,
    output logic                  host_ready_o,
    soc_bus_if.master             m_bus
);

    import uninasoc_pkg::*;

    localparam int        REGION_LSB = `REGION_MSB - 3;
    localparam bus_addr_t MEM_REGION  = `MEM_BASE;
    localparam bus_addr_t PLIC_REGION = `PLIC_BASE;

    logic       req_valid_q;   // command register full
    logic       host_accept;
    slave_sel_e sel_d;

    ////////////////////////////////////////
    // address decode
    ////////////////////////////////////////

    always_comb begin
        sel_d = SEL_NONE;   // unknown region
        if (host_addr_i[1:0] == 2'b00) begin   // word aligned only
            if (host_addr_i[`REGION_MSB:REGION_LSB] == MEM_REGION[`REGION_MSB:REGION_LSB])
                sel_d = SEL_MEM;
            else if (host_addr_i[`REGION_MSB:REGION_LSB] == PLIC_REGION[`REGION_MSB:REGION_LSB])
                sel_d = SEL_PLIC;
        end
    end

    // free slot, or current request leaves this edge
    assign host_ready_o = !req_valid_q || m_bus.ready;
    assign host_accept  = host_req_i && host_ready_o;

    ////////////////////////////////////////
    // command register
    ////////////////////////////////////////

    always_ff @(posedge sys_clock_i) begin
        if (rst_i) begin
            req_valid_q <= 1'b0;
        end else if (host_accept) begin
            req_valid_q <= 1'b1;
        end else if (m_bus.ready) begin
            req_valid_q <= 1'b0;   // transferred
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (host_accept) begin
            m_bus.op    <= host_we_i ? OP_WRITE : OP_READ;
            m_bus.sel   <= sel_d;
            m_bus.addr  <= host_addr_i;
            m_bus.wdata <= host_wdata_i;
        end
    end

    assign m_bus.valid = req_valid_q;

    // request held steady until the queue takes it
    a_req_stable: assert property (@(posedge sys_clock_i) disable iff (rst_i)
        m_bus.valid && !m_bus.ready |=> m_bus.valid && $stable(m_bus.op) &&
        $stable(m_bus.sel) && $stable(m_bus.addr) && $stable(m_bus.wdata));

endmodule : sys_master

// ==== uninasoc.sv ====
// uninasoc top level: host master, request queue and main bus with its slaves
`timescale 1ns/10ps

module uninasoc (
    // clock and reset
    input  logic                    sys_clock_i,
    input  logic                    rst_i,

    // host command side
    input  logic                    host_req_i,
    input  logic                    host_we_i,
    input  uninasoc_pkg::bus_addr_t host_addr_i,
    input  uninasoc_pkg::bus_data_t host_wdata_i,
    output logic                    host_ready_o,

    // host response side
    output logic                    host_rsp_valid_o,
    output uninasoc_pkg::bus_data_t host_rdata_o,
    output logic                    host_rsp_err_o,
    input  logic                    host_rsp_ready_i,

    // peripheral interrupt lines and platform irq
    input  uninasoc_pkg::irq_vec_t  irq_src_i,
    output logic                    irq_o
);

    ////////////////////////////////////////
    // request buses
    ////////////////////////////////////////

    soc_bus_if mst_bus ();    // master -> queue
    soc_bus_if fifo_bus ();   // queue -> main bus

    ////////////////////////////////////////
    // blocks
    ////////////////////////////////////////

    sys_master i_sys_master (
        .sys_clock_i  ( sys_clock_i  ),
        .rst_i        ( rst_i        ),
        .host_req_i   ( host_req_i   ),
        .host_we_i    ( host_we_i    ),
        .host_addr_i  ( host_addr_i  ),
        .host_wdata_i ( host_wdata_i ),
        .host_ready_o ( host_ready_o ),
        .m_bus        ( mst_bus      )
    );

    req_fifo i_req_fifo (
        .sys_clock_i ( sys_clock_i ),
        .rst_i       ( rst_i       ),
        .s_bus       ( mst_bus     ),
        .m_bus       ( fifo_bus    )
    );

    main_bus i_main_bus (
        .sys_clock_i      ( sys_clock_i      ),
        .rst_i            ( rst_i            ),
        .s_bus            ( fifo_bus         ),
        .host_rsp_ready_i ( host_rsp_ready_i ),
        .host_rsp_valid_o ( host_rsp_valid_o ),
        .host_rdata_o     ( host_rdata_o     ),
        .host_rsp_err_o   ( host_rsp_err_o   ),
        .irq_src_i        ( irq_src_i        ),
        .irq_o            ( irq_o            )
    );

endmodule : uninasoc

// ==== tb_uninasoc.sv ====
// uninasoc testbench: random host traffic and irq patterns checked against a reference model
`timescale 1ns/10ps
`include "uninasoc_macros.svh"

module tb_uninasoc;

    import uninasoc_pkg::*;

    localparam int NUM_CMDS       = 220;   // upper bound over all tests
    localparam int TIMEOUT_CYCLES = 20 * NUM_CMDS + 1000;
    localparam int FILL_LIMIT     = `REQ_FIFO_DEPTH + 2;   // master reg + queue + rsp reg
    localparam int N_MEM          = 40;
    localparam int N_ERR          = 8;
    localparam int N_IRQ          = 10;
    localparam bus_addr_t PLIC_EN_ADDR   = `PLIC_BASE;
    localparam bus_addr_t PLIC_PEND_ADDR = `PLIC_BASE + 32'h4;

    // host response ready behaviour
    localparam int RSP_RANDOM = 0;
    localparam int RSP_SLOW   = 1;   // ready one cycle in four
    localparam int RSP_HOLD   = 2;

    logic      sys_clock_i, rst_i;
    logic      host_req_i, host_we_i, host_ready_o;
    bus_addr_t host_addr_i;
    bus_data_t host_wdata_i, host_rdata_o;
    logic      host_rsp_valid_o, host_rsp_err_o, host_rsp_ready_i;
    irq_vec_t  irq_src_i;
    logic      irq_o;

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    bus_data_t   mem_model [`MEM_WORDS];   // indexed by addr[9:2]
    logic [7:0]  written_idx [$];          // words safe to read
    irq_vec_t    pend_model, en_model;
    bus_data_t   exp_rdata_q [$];          // expected responses, command order
    logic        exp_err_q [$];
    logic [31:0] stim_state, rsp_state;
    int          rsp_mode;
    int          cycle_cnt;

    uninasoc i_uninasoc (
        .sys_clock_i      ( sys_clock_i      ),
        .rst_i            ( rst_i            ),
        .host_req_i       ( host_req_i       ),
        .host_we_i        ( host_we_i        ),
        .host_addr_i      ( host_addr_i      ),
        .host_wdata_i     ( host_wdata_i     ),
        .host_ready_o     ( host_ready_o     ),
        .host_rsp_valid_o ( host_rsp_valid_o ),
        .host_rdata_o     ( host_rdata_o     ),
        .host_rsp_err_o   ( host_rsp_err_o   ),
        .host_rsp_ready_i ( host_rsp_ready_i ),
        .irq_src_i        ( irq_src_i        ),
        .irq_o            ( irq_o            )
    );

    initial begin
        sys_clock_i = 1'b0;
        forever #50 sys_clock_i = ~sys_clock_i;   // 100 ns period
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic logic [31:0] lcg_step(inout logic [31:0] state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state;
    endfunction

    // two lcg steps, upper halves only
    function automatic logic [31:0] stim_rand();
        logic [31:0] hi, lo;
        hi = lcg_step(stim_state);
        lo = lcg_step(stim_state);
        return {hi[31:16], lo[31:16]};
    endfunction

    // memory region, random alias bits above the word index
    function automatic bus_addr_t mem_addr(input logic [7:0] idx);
        logic [31:0] r;
        r = stim_rand();
        return {4'h0, r[17:0], idx, 2'b00};
    endfunction

    function automatic logic [7:0] pick_written();
        logic [31:0] r;
        r = stim_rand();
        return written_idx[r % written_idx.size()];
    endfunction

    task automatic abort_run(input string reason);
        $display("ERROR: %s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    // called at a falling edge, returns at the falling edge after acceptance
    task automatic issue_cmd(input logic we, input bus_addr_t addr, input bus_data_t wdata,
                             input bus_data_t exp_rdata, input logic exp_err);
        host_req_i   = 1'b1;
        host_we_i    = we;
        host_addr_i  = addr;
        host_wdata_i = wdata;
        exp_rdata_q.push_back(exp_rdata);
        exp_err_q.push_back(exp_err);
        while (!host_ready_o) begin
            @(negedge sys_clock_i);   // master register busy
        end
        @(negedge sys_clock_i);
        host_req_i = 1'b0;
    endtask

    task automatic mem_write(input logic [7:0] idx, input bus_data_t data);
        bus_addr_t addr;
        addr = mem_addr(idx);
        mem_model[idx] = data;
        written_idx.push_back(idx);
        issue_cmd(1'b1, addr, data, '0, 1'b0);
    endtask

    task automatic mem_read(input logic [7:0] idx);
        bus_addr_t addr;
        bus_data_t junk;
        addr = mem_addr(idx);
        junk = stim_rand();   // wdata ignored on reads
        issue_cmd(1'b0, addr, junk, mem_model[idx], 1'b0);
    endtask

    task automatic random_mem_cmd();
        logic [31:0] r;
        r = stim_rand();
        if (r[31]) begin
            mem_write(r[7:0], stim_rand());
        end else begin
            mem_read(pick_written());
        end
    endtask

    task automatic plic_write(input bus_addr_t addr, input bus_data_t data);
        if (addr == PLIC_EN_ADDR) begin
            en_model = data[`NUM_IRQ_SRC-1:0];
        end else begin
            // write-1-clear, a live source keeps its bit
            pend_model = (pend_model & ~data[`NUM_IRQ_SRC-1:0]) | irq_src_i;
        end
        issue_cmd(1'b1, addr, data, '0, 1'b0);
    endtask

    task automatic plic_read(input bus_addr_t addr);
        bus_data_t exp;
        exp = (addr == PLIC_EN_ADDR) ? bus_data_t'(en_model) : bus_data_t'(pend_model);
        issue_cmd(1'b0, addr, '0, exp, 1'b0);
    endtask

    task automatic set_sources(input irq_vec_t src);
        irq_src_i  = src;
        pend_model = pend_model | src;   // level sets pending
    endtask

    task automatic wait_drain();
        while (exp_rdata_q.size() != 0) begin
            @(negedge sys_clock_i);
        end
    endtask

    ////////////////////////////////////////
    // response side
    ////////////////////////////////////////

    initial begin
        logic [31:0] r;
        bus_data_t   exp_rdata;
        logic        exp_err;
        forever begin
            @(negedge sys_clock_i);
            r = lcg_step(rsp_state);
            case (rsp_mode)
                RSP_RANDOM: host_rsp_ready_i = r[31];
                RSP_SLOW:   host_rsp_ready_i = (r[31:30] == 2'b00);
                default:    host_rsp_ready_i = 1'b0;
            endcase
            if (!rst_i && host_rsp_valid_o && host_rsp_ready_i) begin   // taken next edge
                if (exp_rdata_q.size() == 0) begin
                    abort_run("response seen with no command outstanding");
                end else begin
                    exp_rdata = exp_rdata_q.pop_front();
                    exp_err   = exp_err_q.pop_front();
                    check_value("host_rdata_o", host_rdata_o, exp_rdata);
                    check_value("host_rsp_err_o", host_rsp_err_o, exp_err);
                end
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge sys_clock_i);
            cycle_cnt++;
        end
        abort_run($sformatf("timeout, run not finished after %0d cycles", TIMEOUT_CYCLES));
    end

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        logic [31:0] r;
        logic [7:0]  idx;
        logic [3:0]  region;
        logic [1:0]  off;
        int          accepted;
        stim_state       = 32'h12ee_6650;
        rsp_state        = lcg_step(stim_state);   // own stream for the ready line
        rsp_mode         = RSP_RANDOM;
        rst_i            = 1'b1;
        host_req_i       = 1'b0;
        host_we_i        = 1'b0;
        host_addr_i      = '0;
        host_wdata_i     = '0;
        host_rsp_ready_i = 1'b0;
        irq_src_i        = '0;
        pend_model       = '0;
        en_model         = '0;
        repeat (10) @(negedge sys_clock_i);
        rst_i = 1'b0;
        check_value("host_ready_o", host_ready_o, 1'b1);
        check_value("host_rsp_valid_o", host_rsp_valid_o, 1'b0);
        check_value("irq_o", irq_o, 1'b0);

        // memory write then read back
        for (int i = 0; i < N_MEM; i++) begin
            r = stim_rand();
            mem_write(r[31:24], stim_rand());
        end
        for (int i = 0; i < N_MEM; i++) begin
            mem_read(pick_written());
        end
        wait_drain();

        // unmapped and misaligned accesses
        for (int i = 0; i < N_ERR; i++) begin
            r   = stim_rand();
            idx = r[31:24];
            mem_write(idx, stim_rand());
            region = r[23:20];
            if (region == 4'h0 || region == 4'h4) begin
                region = 4'h9;   // force unmapped
            end
            off = (r[1:0] == 2'b00) ? 2'b10 : r[1:0];
            issue_cmd(1'b1, {region, r[19:2], idx, 2'b00}, ~r, '0, 1'b1);
            issue_cmd(1'b1, {4'h0, r[19:2], idx, off}, r, '0, 1'b1);
            issue_cmd(1'b0, {region, r[19:2], idx, 2'b00}, '0, '0, 1'b1);
            mem_read(idx);   // word must be untouched
        end
        wait_drain();

        // back-pressure, host stops taking responses
        rsp_mode = RSP_HOLD;
        accepted = 0;
        while (host_ready_o && accepted < FILL_LIMIT) begin
            random_mem_cmd();
            accepted++;
        end
        if (host_ready_o) begin
            abort_run("host_ready_o stayed high with the response path stalled");
        end
        repeat (30) begin
            @(negedge sys_clock_i);
            check_value("host_ready_o", host_ready_o, 1'b0);
        end
        rsp_mode = RSP_SLOW;
        repeat (24) random_mem_cmd();   // order and loss caught by the queue
        wait_drain();

        // pending bits
        rsp_mode = RSP_RANDOM;
        for (int i = 0; i < N_IRQ; i++) begin
            wait_drain();   // no pending read in flight while sources move
            r = stim_rand();
            set_sources(r[3:0]);
            repeat (3) @(negedge sys_clock_i);
            set_sources(r[7:4] & r[11:8]);   // some sources drop
            repeat (2) @(negedge sys_clock_i);
            plic_write(PLIC_PEND_ADDR, r >> 12);
            plic_read(PLIC_PEND_ADDR);
        end

        // irq output vs enable and pending
        for (int i = 0; i < N_IRQ; i++) begin
            wait_drain();
            r = stim_rand();
            set_sources(r[3:0] & r[7:4]);
            repeat (2) @(negedge sys_clock_i);
            check_value("irq_o", irq_o, |(pend_model & en_model));
            plic_write(PLIC_PEND_ADDR, r >> 8);
            plic_write(PLIC_EN_ADDR, r >> 12);
            plic_read(PLIC_EN_ADDR);
            wait_drain();
            repeat (2) @(negedge sys_clock_i);
            check_value("irq_o", irq_o, |(pend_model & en_model));
        end
        wait_drain();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule : tb_uninasoc

// ==== vlog.f ====
+incdir+.
uninasoc_pkg.sv
soc_bus_if.sv
main_memory.sv
plic.sv
main_bus.sv
req_fifo.sv
sys_master.sv
uninasoc.sv
tb_uninasoc.sv
